/* source/bjp_decode.sv */
/*
 branch/jump decode: operation flags, compare operands
 and the two target adder operands per instruction format
*/

`timescale 1ns/1ps

module bjp_decode
    import rv_isa_pkg::*;
    import bru_pkg::*;
(
    input  issue_t          issue_i,
    output logic            req_bjp_o,         // branch or jalr in flight
    output bjp_op_t         op_o,
    output logic [XLEN-1:0] op1_o,             // compare operands
    output logic [XLEN-1:0] op2_o,
    output logic [XLEN-1:0] jump_op1_o,        // target adder operands
    output logic [XLEN-1:0] jump_op2_o,
    output logic            is_pred_branch_o
);

    rv_inst_u        inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;
    logic            is_branch;
    logic            is_jalr;

    assign inst   = issue_i.inst;
    assign opcode = inst.b.opcode;  // same slot in every view
    assign funct3 = inst.b.funct3;  // unused by J, only read for B and I

    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jalr   = (opcode == OPC_JALR);

    // B immediate, 13 bits, lsb implied zero
    assign imm_b = {{(XLEN-12){inst.b.imm12}}, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    // J immediate, 21 bits, lsb implied zero
    assign imm_j = {{(XLEN-20){inst.j.imm20}}, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    // I immediate, plain sign extension
    assign imm_i = {{(XLEN-12){inst.i.imm11_0[11]}}, inst.i.imm11_0};

    assign req_bjp_o        = issue_i.valid & (is_branch | is_jalr);
    assign is_pred_branch_o = issue_i.valid & issue_i.pred_taken & is_branch;  // jal/jalr ignored

    assign op1_o = issue_i.rs1_data;
    assign op2_o = issue_i.rs2_data;

    // operation flags, at most one set
    always_comb begin
        op_o = '0;
        if (issue_i.valid) begin
            case (opcode)
                OPC_BRANCH: begin
                    case (funct3)
                        F3_BEQ:  op_o.beq  = 1'b1;
                        F3_BNE:  op_o.bne  = 1'b1;
                        F3_BLT:  op_o.blt  = 1'b1;
                        F3_BGE:  op_o.bge  = 1'b1;
                        F3_BLTU: op_o.bltu = 1'b1;
                        F3_BGEU: op_o.bgeu = 1'b1;
                        default: ;                    // 010/011 reserved
                    endcase
                end
                OPC_JAL:      op_o.jal   = 1'b1;
                OPC_JALR:     op_o.jalr  = (funct3 == F3_JALR);
                OPC_MISC_MEM: op_o.fence = (funct3 == F3_FENCE);
                default: ;
            endcase
        end
    end

    // target operands by format
    always_comb begin
        case (opcode)
            OPC_BRANCH: begin
                jump_op1_o = issue_i.pc;
                jump_op2_o = imm_b;
            end
            OPC_JAL: begin
                jump_op1_o = issue_i.pc;
                jump_op2_o = imm_j;
            end
            OPC_JALR: begin
                jump_op1_o = issue_i.rs1_data;  // register relative
                jump_op2_o = imm_i;
            end
            default: begin
                jump_op1_o = issue_i.pc;        // fence refetches pc+4
                jump_op2_o = XLEN'(4);
            end
        endcase
    end

endmodule

/* source/bru_pkg.sv */
/*
 branch unit records: operation flags, issued instruction,
 front-end redirect and misaligned-fetch fault
*/

package bru_pkg;

    import rv_isa_pkg::*;

    // one-hot per recognised jump/branch, all zero otherwise
    typedef struct packed {
        logic jal;
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
        logic jalr;
        logic fence;
    } bjp_op_t;

    // instruction as handed over by issue
    typedef struct packed {
        logic                       valid;
        logic [31:0]                inst;
        logic [INST_ADDR_WIDTH-1:0] pc;
        logic [XLEN-1:0]            rs1_data;
        logic [XLEN-1:0]            rs2_data;
        logic                       pred_taken;  // front end already followed it
    } issue_t;

    // redirect to the front end
    typedef struct packed {
        logic                       valid;
        logic [INST_ADDR_WIDTH-1:0] addr;
        logic                       pred_hit;    // prediction confirmed, no redirect
    } redirect_t;

    // misaligned fetch fault record for the trap unit
    typedef struct packed {
        logic                       valid;
        logic [INST_ADDR_WIDTH-1:0] epc;         // pc of the jump itself
        logic [INST_ADDR_WIDTH-1:0] badaddr;     // offending target
    } fault_t;

endpackage

/* source/exu_branch_top.sv */
/*
 branch slice top: decode, resolve, register
 one cycle from issue to redirect/fault
*/

`timescale 1ns/1ps

module exu_branch_top
    import rv_isa_pkg::*;
    import bru_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  issue_t    issue_i,
    input  logic      int_assert_i,
    output redirect_t redirect_o,
    output fault_t    fault_o
);

    // decode to bru
    logic                       req_bjp;
    bjp_op_t                    bjp_op;
    logic [XLEN-1:0]            op1;
    logic [XLEN-1:0]            op2;
    logic [XLEN-1:0]            jump_op1;
    logic [XLEN-1:0]            jump_op2;
    logic                       is_pred_branch;

    // bru to register stage
    logic                       jump_flag;
    logic [INST_ADDR_WIDTH-1:0] jump_addr;
    logic                       pred_taken;
    logic                       misaligned_fetch;

    bjp_decode bjp_decode_inst (
        .issue_i          (issue_i),
        .req_bjp_o        (req_bjp),
        .op_o             (bjp_op),
        .op1_o            (op1),
        .op2_o            (op2),
        .jump_op1_o       (jump_op1),
        .jump_op2_o       (jump_op2),
        .is_pred_branch_o (is_pred_branch)
    );

    exu_bru exu_bru_inst (
        .req_bjp_i          (req_bjp),
        .bjp_op_i           (bjp_op),
        .bjp_op1_i          (op1),
        .bjp_op2_i          (op2),
        .bjp_jump_op1_i     (jump_op1),
        .bjp_jump_op2_i     (jump_op2),
        .is_pred_branch_i   (is_pred_branch),
        .int_assert_i       (int_assert_i),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr),
        .pred_taken_o       (pred_taken),
        .misaligned_fetch_o (misaligned_fetch)
    );

    redirect_reg redirect_reg_inst (
        .clk                (clk),
        .reset_i            (reset_i),
        .issue_i            (issue_i),
        .jump_flag_i        (jump_flag),
        .jump_addr_i        (jump_addr),
        .pred_taken_i       (pred_taken),
        .misaligned_fetch_i (misaligned_fetch),
        .redirect_o         (redirect_o),
        .fault_o            (fault_o)
    );

endmodule

/* source/exu_bru.sv */
/*
 branch resolution: condition compare, shared target adder,
 prediction rollback, misaligned target and interrupt masking
*/

`timescale 1ns/1ps

module exu_bru
    import rv_isa_pkg::*;
    import bru_pkg::*;
(
    input  logic                       req_bjp_i,
    input  bjp_op_t                    bjp_op_i,
    input  logic [XLEN-1:0]            bjp_op1_i,        // rs1
    input  logic [XLEN-1:0]            bjp_op2_i,        // rs2
    input  logic [XLEN-1:0]            bjp_jump_op1_i,   // pc or rs1
    input  logic [XLEN-1:0]            bjp_jump_op2_i,   // immediate or 4
    input  logic                       is_pred_branch_i, // front end took it already
    input  logic                       int_assert_i,     // pending interrupt wins
    output logic                       jump_flag_o,
    output logic [INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                       pred_taken_o,     // prediction confirmed
    output logic                       misaligned_fetch_o
);

    logic                       op1_eq_op2;
    logic                       op1_ge_op2_signed;
    logic                       op1_ge_op2_unsigned;
    logic                       branch_cond;
    logic                       pred_rollback;
    logic                       jump_req;                // before masking
    logic [XLEN-1:0]            adder_op2;
    logic [XLEN-1:0]            adder_result;
    logic [INST_ADDR_WIDTH-1:0] target;

    // one comparator set serves all six branches
    assign op1_eq_op2          = (bjp_op1_i == bjp_op2_i);
    assign op1_ge_op2_signed   = ($signed(bjp_op1_i) >= $signed(bjp_op2_i));
    assign op1_ge_op2_unsigned = (bjp_op1_i >= bjp_op2_i);

    // jalr is unconditional, counts as condition true
    assign branch_cond = req_bjp_i & (
        (bjp_op_i.beq  &  op1_eq_op2)          |
        (bjp_op_i.bne  & ~op1_eq_op2)          |
        (bjp_op_i.blt  & ~op1_ge_op2_signed)   |
        (bjp_op_i.bge  &  op1_ge_op2_signed)   |
        (bjp_op_i.bltu & ~op1_ge_op2_unsigned) |
        (bjp_op_i.bgeu &  op1_ge_op2_unsigned) |
        bjp_op_i.jalr
    );

    // predicted taken but falls through, front end must go back to pc+4
    assign pred_rollback = is_pred_branch_i & req_bjp_i & ~branch_cond;
    assign pred_taken_o  = is_pred_branch_i & branch_cond;

    // single adder, rollback swaps the offset for 4
    assign adder_op2    = pred_rollback ? XLEN'(4) : bjp_jump_op2_i;
    assign adder_result = bjp_jump_op1_i + adder_op2;

    // jalr drops bit 0 per spec
    assign target = bjp_op_i.jalr ? (adder_result & ~INST_ADDR_WIDTH'(1)) : adder_result;
    assign jump_addr_o = target;

    assign jump_req = (branch_cond & ~is_pred_branch_i) | bjp_op_i.fence | pred_rollback;

    // jal is checked here even though the front end already redirected
    assign misaligned_fetch_o = (target[1:0] != 2'b00) & (jump_req | bjp_op_i.jal);

    // fault or interrupt suppresses the redirect
    assign jump_flag_o = jump_req & ~misaligned_fetch_o & ~int_assert_i;

endmodule

/* source/redirect_reg.sv */
/*
 output stage: registered redirect and misaligned-fetch fault capture
*/

`timescale 1ns/1ps

module redirect_reg
    import rv_isa_pkg::*;
    import bru_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  issue_t                     issue_i,            // pc for the fault record
    input  logic                       jump_flag_i,
    input  logic [INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                       pred_taken_i,
    input  logic                       misaligned_fetch_i,
    output redirect_t                  redirect_o,
    output fault_t                     fault_o
);

    // strobes, cleared by reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o.valid    <= 1'b0;
            redirect_o.pred_hit <= 1'b0;
            fault_o.valid       <= 1'b0;
        end else begin
            redirect_o.valid    <= jump_flag_i;         // one cycle pulse
            redirect_o.pred_hit <= pred_taken_i;
            fault_o.valid       <= misaligned_fetch_i;
        end
    end

    // redirect target, only loaded with a redirect
    always_ff @(posedge clk) begin
        if (jump_flag_i) begin
            redirect_o.addr <= jump_addr_i;
        end
    end

    // fault payload, kept until the next fault
    always_ff @(posedge clk) begin
        if (misaligned_fetch_i) begin
            fault_o.epc     <= issue_i.pc;     // the jump, not its target
            fault_o.badaddr <= jump_addr_i;
        end
    end

endmodule

/* source/rv_isa_pkg.sv */
/*
 RV32I widths, major opcodes and funct3 codes used by branch resolution,
 plus the B, J and I format views of one instruction word
*/

package rv_isa_pkg;

    localparam int XLEN            = 32;  // data path width
    localparam int INST_ADDR_WIDTH = 32;  // fetch address width

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

    // conditional branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // jalr and plain fence only use funct3 zero
    localparam logic [2:0] F3_JALR  = 3'b000;
    localparam logic [2:0] F3_FENCE = 3'b000;  // 3'b001 would be fence.i

    // B type, conditional branches
    typedef struct packed {
        logic       imm12;     // sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;     // sits in the rd[0] slot
        logic [6:0] opcode;
    } rv_b_fmt_t;

    // J type, jal
    typedef struct packed {
        logic       imm20;     // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    // I type, jalr and fence
    typedef struct packed {
        logic [11:0] imm11_0;  // contiguous, sign at bit 11
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    // one word, three decodings picked by opcode
    typedef union packed {
        rv_b_fmt_t b;
        rv_j_fmt_t j;
        rv_i_fmt_t i;
    } rv_inst_u;

endpackage

/* src.f */
source/rv_isa_pkg.sv
source/bru_pkg.sv
source/bjp_decode.sv
source/exu_bru.sv
source/redirect_reg.sv
source/exu_branch_top.sv
tb/tb_clkgen.sv
tb/exu_branch_chk.sv
tb/exu_branch_tb.sv

/* tb/exu_branch_chk.sv */
/*
 concurrent checks on the branch slice outputs, bound into the top level
*/

`timescale 1ns/1ps

module exu_branch_chk
    import bru_pkg::*;
(
    input logic      clk_i,
    input logic      reset_i,
    input issue_t    issue_i,
    input redirect_t redirect_i,
    input fault_t    fault_i
);

    int unsigned fail_cnt = 0;  // property failures so far

    // registered under reset, so quiet one cycle later
    quiet_after_reset: assert property (
        @(posedge clk_i) reset_i |=> (!redirect_i.valid && !fault_i.valid))
        else begin
            $error("redirect or fault valid in the cycle after reset");
            fail_cnt++;
        end

    // a faulting target never redirects
    no_redirect_with_fault: assert property (
        @(posedge clk_i) disable iff (reset_i) !(redirect_i.valid && fault_i.valid))
        else begin
            $error("redirect and fault valid in the same cycle");
            fail_cnt++;
        end

    // one cycle latency from issue
    valid_needs_issue: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (redirect_i.valid || fault_i.valid) |-> $past(issue_i.valid))
        else begin
            $error("output valid without an issue one cycle earlier");
            fail_cnt++;
        end

endmodule

bind exu_branch_top exu_branch_chk exu_branch_chk_inst (
    .clk_i      (clk),
    .reset_i    (reset_i),
    .issue_i    (issue_i),
    .redirect_i (redirect_o),
    .fault_i    (fault_o)
);

/* tb/exu_branch_tb.sv */
/*
 branch slice testbench: random branch, jump and fence stimulus,
 reference model one cycle behind, output checks and run timeout
*/

`timescale 1ns/1ps

module exu_branch_tb
    import rv_isa_pkg::*;
    import bru_pkg::*;
();

    localparam int N_BRANCH = 120;  // unpredicted branches
    localparam int N_PRED   = 80;   // predicted taken
    localparam int N_JUMP   = 40;   // jalr, jal, fence triplets
    localparam int N_INT    = 60;   // interrupt pending
    localparam int N_MIX    = 80;   // back to back with idles and alu ops
    localparam int NUM_ISSUES     = N_BRANCH + N_PRED + 3 * N_JUMP + N_INT + N_MIX + 2;
    localparam int TIMEOUT_CYCLES = NUM_ISSUES + 20;

    localparam int K_BRANCH = 0;
    localparam int K_JAL    = 1;
    localparam int K_JALR   = 2;
    localparam int K_FENCE  = 3;
    localparam int K_OTHER  = 4;
    localparam int K_IDLE   = 5;

    logic        clk;
    logic        reset_i;
    issue_t      issue_i;
    logic        int_assert_i;
    redirect_t   redirect_o;
    fault_t      fault_o;
    redirect_t   exp_redir_in;     // model result for the instruction on issue_i
    redirect_t   exp_redir_out;    // same, aligned with the DUT output
    fault_t      exp_fault_in;
    fault_t      exp_fault_out;
    int          cycle_cnt = 0;

    tb_clkgen tb_clkgen_inst (.clk_o(clk), .reset_o(reset_i));

    exu_branch_top exu_branch_top_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .issue_i      (issue_i),
        .int_assert_i (int_assert_i),
        .redirect_o   (redirect_o),
        .fault_o      (fault_o)
    );

    // equal and sign-boundary values mixed into the random ones
    function automatic logic [31:0] pick_operand(input logic [31:0] other);
        case ($urandom_range(5))
            0:       return other;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            3:       return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    // expected redirect and fault, straight from the branch rules
    function automatic void expect_result(input issue_t it, input logic [31:0] imm,
                                          input logic intr, output redirect_t r,
                                          output fault_t f);
        rv_inst_u    w;
        logic [31:0] tgt;
        logic        cond;
        logic        redir;
        logic        is_jal;
        w      = it.inst;
        r      = '0;
        f      = '0;
        tgt    = '0;
        cond   = 1'b0;
        redir  = 1'b0;
        is_jal = 1'b0;
        if (it.valid) begin
            case (w.b.opcode)
                OPC_BRANCH: begin
                    case (w.b.funct3)
                        F3_BEQ:  cond = (it.rs1_data == it.rs2_data);
                        F3_BNE:  cond = (it.rs1_data != it.rs2_data);
                        F3_BLT:  cond = ($signed(it.rs1_data) < $signed(it.rs2_data));
                        F3_BGE:  cond = ($signed(it.rs1_data) >= $signed(it.rs2_data));
                        F3_BLTU: cond = (it.rs1_data < it.rs2_data);
                        default: cond = (it.rs1_data >= it.rs2_data);  // bgeu
                    endcase
                    if (it.pred_taken) begin
                        r.pred_hit = cond;           // front end was right
                        redir      = !cond;          // roll back to fall-through
                        tgt        = it.pc + 32'd4;
                    end else begin
                        redir = cond;
                        tgt   = it.pc + imm;
                    end
                end
                OPC_JAL: begin
                    is_jal = 1'b1;                   // alignment check only
                    tgt    = it.pc + imm;
                end
                OPC_JALR: begin
                    redir = 1'b1;
                    tgt   = (it.rs1_data + imm) & 32'hffff_fffe;
                end
                OPC_MISC_MEM: begin
                    redir = 1'b1;
                    tgt   = it.pc + 32'd4;           // refetch after fence
                end
                default: ;
            endcase
        end
        f.valid   = (redir | is_jal) & (tgt[1:0] != 2'b00);
        f.epc     = it.pc;
        f.badaddr = tgt;
        r.valid   = redir & !f.valid & !intr;     // interrupt masks only the redirect
        r.addr    = tgt;
    endfunction

    // random instruction of one kind, immediate packed through the format view
    task automatic build_issue(input int kind, input logic pred,
                               output issue_t it, output logic [31:0] imm);
        rv_inst_u    w;
        logic [2:0]  f3;
        logic [31:0] raw;
        raw           = $urandom;
        w             = $urandom;                // random register fields
        imm           = '0;
        it.valid      = (kind != K_IDLE);
        it.pc         = $urandom & 32'hffff_fffc;
        it.rs1_data   = $urandom;
        it.rs2_data   = pick_operand(it.rs1_data);
        it.pred_taken = pred;
        case (kind)
            K_JAL: begin
                imm          = {{11{raw[20]}}, raw[20:1], 1'b0};
                w.j.opcode   = OPC_JAL;
                w.j.imm20    = raw[20];
                w.j.imm19_12 = raw[19:12];
                w.j.imm11    = raw[11];
                w.j.imm10_1  = raw[10:1];
            end
            K_JALR: begin
                imm         = {{20{raw[11]}}, raw[11:0]};  // odd sums allowed
                w.i.opcode  = OPC_JALR;
                w.i.funct3  = F3_JALR;
                w.i.imm11_0 = raw[11:0];
            end
            K_FENCE: begin
                w.i.opcode = OPC_MISC_MEM;
                w.i.funct3 = F3_FENCE;
            end
            K_OTHER: w.b.opcode = 7'b0110011;    // register alu op
            default: begin                       // branch, also the idle pattern
                do begin
                    f3 = 3'($urandom);
                end while (f3[2:1] == 2'b01);    // skip reserved codes
                imm         = {{19{raw[12]}}, raw[12:1], 1'b0};
                w.b.opcode  = OPC_BRANCH;
                w.b.funct3  = f3;
                w.b.imm12   = raw[12];
                w.b.imm11   = raw[11];
                w.b.imm10_5 = raw[10:5];
                w.b.imm4_1  = raw[4:1];
            end
        endcase
        it.inst = w;
    endtask

    // one instruction per rising edge, expectation travels alongside
    task automatic issue_one(input int kind, input logic pred, input logic intr);
        issue_t      it;
        logic [31:0] imm;
        redirect_t   r;
        fault_t      f;
        build_issue(kind, pred, it, imm);
        expect_result(it, imm, intr, r, f);
        @(posedge clk);
        issue_i      <= it;
        int_assert_i <= intr;
        exp_redir_in <= r;
        exp_fault_in <= f;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Error: %s = 0x%h, expected 0x%h", name, got, want);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // DUT registers the issue at this edge
    always @(posedge clk) begin
        exp_redir_out <= exp_redir_in;
        exp_fault_out <= exp_fault_in;
    end

    // outputs settled mid-cycle
    always @(negedge clk) begin
        if (!reset_i) begin
            assert (redirect_o.valid === exp_redir_out.valid)
                else report_mismatch("redirect_o.valid", redirect_o.valid, exp_redir_out.valid);
            assert (redirect_o.pred_hit === exp_redir_out.pred_hit)
                else report_mismatch("redirect_o.pred_hit", redirect_o.pred_hit,
                                     exp_redir_out.pred_hit);
            if (exp_redir_out.valid) begin
                assert (redirect_o.addr === exp_redir_out.addr)
                    else report_mismatch("redirect_o.addr", redirect_o.addr, exp_redir_out.addr);
            end
            assert (fault_o.valid === exp_fault_out.valid)
                else report_mismatch("fault_o.valid", fault_o.valid, exp_fault_out.valid);
            if (exp_fault_out.valid) begin
                assert (fault_o.epc === exp_fault_out.epc)
                    else report_mismatch("fault_o.epc", fault_o.epc, exp_fault_out.epc);
                assert (fault_o.badaddr === exp_fault_out.badaddr)
                    else report_mismatch("fault_o.badaddr", fault_o.badaddr,
                                         exp_fault_out.badaddr);
            end
        end
    end

    // property failures in the bound checker
    always @(negedge clk) begin
        if (exu_branch_top_inst.exu_branch_chk_inst.fail_cnt != 0) begin
            $display("Error: a concurrent assertion on the DUT outputs failed");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles, testbench hung", cycle_cnt);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(79061));
        issue_i       = '0;
        issue_i.valid = 1'b1;                    // jumps held against reset
        issue_i.inst  = {25'd0, OPC_MISC_MEM};   // fence, redirects unless reset
        int_assert_i  = 1'b0;
        exp_redir_in  = '0;
        exp_fault_in  = '0;
        @(posedge clk);
        issue_i.inst <= 32'h0020_006f;           // jal +2, faults unless reset
        wait (reset_i === 1'b0);
        issue_i <= '0;
        repeat (N_BRANCH) issue_one(K_BRANCH, 1'b0, 1'b0);
        repeat (N_PRED) issue_one(K_BRANCH, 1'b1, 1'b0);
        repeat (N_JUMP) begin
            issue_one(K_JALR, 1'($urandom_range(1)), 1'b0);  // prediction ignored
            issue_one(K_JAL, 1'b0, 1'b0);
            issue_one(K_FENCE, 1'b0, 1'b0);
        end
        repeat (N_INT) issue_one($urandom_range(K_FENCE), 1'($urandom_range(1)), 1'b1);
        repeat (N_MIX) issue_one($urandom_range(K_IDLE), 1'($urandom_range(1)), 1'b0);
        repeat (2) issue_one(K_IDLE, 1'b0, 1'b0);           // drain the pipe
        repeat (2) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb/tb_clkgen.sv */
/*
 testbench clock, 100 ns period, and synchronous reset for three cycles
*/

`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;           // released on the third rising edge
    end

    always #50 clk_o = ~clk_o;     // half period

endmodule
